/* core_pkg.sv */
package core_pkg;

    // machine word and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes still decoded
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct7 selectors
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;

    // alu operation select
    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_LUI  = 4'd10;

    // one restoring step per cycle
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = 6;

    // same word seen as register and immediate format
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_view;
    } inst_u;

endpackage

/* frontend.sv */
module frontend (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [core_pkg::XLEN-1:0]        rom_data_i,
    input  logic                             div_busy_i,
    input  logic                             div_done_i,
    output logic                             rom_ce_o,
    output logic [core_pkg::XLEN-1:0]        rom_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rd_addr_o,
    output logic                             exec_valid_o,
    output logic [core_pkg::ALU_OP_W-1:0]    alu_op_o,
    output logic                             use_imm_o,
    output logic [core_pkg::XLEN-1:0]        imm_o,
    output logic                             is_div_o,
    output logic                             div_start_o,
    output logic                             div_signed_o,
    output logic                             div_rem_o
);
    import core_pkg::*;

    logic            ce_q;
    logic [XLEN-1:0] pc_q;
    inst_u           ir_q;
    logic            valid_q;
    logic            issued_q;
    logic            dec_ok;
    logic            dec_div;
    logic            stall;
    logic            fetch;

    // funct3 to alu op, alt picks sub / sra
    function automatic logic [ALU_OP_W-1:0] f3_op(input logic [2:0] funct3, input logic alt);
        logic [ALU_OP_W-1:0] op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        dec_ok    = 1'b0;
        dec_div   = 1'b0;
        use_imm_o = 1'b0;
        alu_op_o  = ALU_ADD;
        imm_o     = {{(XLEN-12){ir_q.i_view.imm12[11]}}, ir_q.i_view.imm12};
        case (ir_q.r_view.opcode)
            OPC_OP: begin
                if (ir_q.r_view.funct7 == FUNCT7_MULDIV) begin
                    // only div/divu/rem/remu, multiplies are dropped
                    dec_ok  = ir_q.r_view.funct3[2];
                    dec_div = ir_q.r_view.funct3[2];
                end else if (ir_q.r_view.funct7 == '0) begin
                    dec_ok   = 1'b1;
                    alu_op_o = f3_op(ir_q.r_view.funct3, 1'b0);
                end else if (ir_q.r_view.funct7 == FUNCT7_ALT) begin
                    dec_ok   = (ir_q.r_view.funct3 == 3'b000) || (ir_q.r_view.funct3 == 3'b101);
                    alu_op_o = f3_op(ir_q.r_view.funct3, 1'b1);
                end
            end
            OPC_OP_IMM: begin
                dec_ok    = 1'b1;
                use_imm_o = 1'b1;
                // srai carries the alt bit inside imm12
                alu_op_o  = f3_op(ir_q.i_view.funct3,
                                  ir_q.i_view.funct3 == 3'b101 && ir_q.i_view.imm12[10]);
            end
            OPC_LUI: begin
                dec_ok    = 1'b1;
                use_imm_o = 1'b1;
                alu_op_o  = ALU_LUI;
                imm_o     = {ir_q.i_view.imm12, ir_q.i_view.rs1, ir_q.i_view.funct3, 12'h000};
            end
            default: ;
        endcase
    end

    assign rom_ce_o   = ce_q;
    assign rom_addr_o = pc_q;
    assign rs1_addr_o = ir_q.r_view.rs1;
    assign rs2_addr_o = ir_q.r_view.rs2;
    assign rd_addr_o  = ir_q.r_view.rd;

    assign exec_valid_o = valid_q && dec_ok;
    assign is_div_o     = dec_div;
    assign div_signed_o = ~ir_q.r_view.funct3[0];
    assign div_rem_o    = ir_q.r_view.funct3[1];

    // hold the divide in the IR until its result comes back
    assign stall       = exec_valid_o && dec_div && !div_done_i;
    assign fetch       = ce_q && !stall;
    assign div_start_o = exec_valid_o && dec_div && !issued_q && !div_busy_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ce_q     <= 1'b0;
            pc_q     <= RESET_PC;
            valid_q  <= 1'b0;
            issued_q <= 1'b0;
        end else begin
            ce_q <= 1'b1;
            if (fetch) begin
                pc_q    <= pc_q + XLEN'(4);
                valid_q <= 1'b1;
            end
            if (div_done_i) begin
                issued_q <= 1'b0;
            end else if (div_start_o) begin
                issued_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch) begin
            ir_q <= inst_u'(rom_data_i);
        end
    end

endmodule

/* regfile.sv */
module regfile (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
    input  logic                             we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  logic [core_pkg::XLEN-1:0]        wdata_i,
    output logic [core_pkg::XLEN-1:0]        rs1_data_o,
    output logic [core_pkg::XLEN-1:0]        rs2_data_o
);
    import core_pkg::*;

    logic [XLEN-1:0] regs_q [2**REG_ADDR_W];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, a same-cycle write is forwarded
    always_comb begin
        if (rs1_addr_i == '0) begin
            rs1_data_o = '0;
        end else if (we_i && waddr_i == rs1_addr_i) begin
            rs1_data_o = wdata_i;
        end else begin
            rs1_data_o = regs_q[rs1_addr_i];
        end
        if (rs2_addr_i == '0) begin
            rs2_data_o = '0;
        end else if (we_i && waddr_i == rs2_addr_i) begin
            rs2_data_o = wdata_i;
        end else begin
            rs2_data_o = regs_q[rs2_addr_i];
        end
    end

endmodule

/* alu_unit.sv */
module alu_unit (
    input  logic [core_pkg::ALU_OP_W-1:0]  alu_op_i,
    input  logic                           use_imm_i,
    input  logic [core_pkg::XLEN-1:0]      imm_i,
    input  logic [core_pkg::XLEN-1:0]      rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]      rs2_data_i,
    output logic [core_pkg::XLEN-1:0]      alu_result_o
);
    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    assign op_a  = rs1_data_i;
    assign op_b  = use_imm_i ? imm_i : rs2_data_i;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  alu_result_o = op_a + op_b;
            ALU_SUB:  alu_result_o = op_a - op_b;
            ALU_SLL:  alu_result_o = op_a << shamt;
            ALU_SLT:  alu_result_o = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_result_o = XLEN'(op_a < op_b);
            ALU_XOR:  alu_result_o = op_a ^ op_b;
            ALU_SRL:  alu_result_o = op_a >> shamt;
            ALU_SRA:  alu_result_o = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_result_o = op_a | op_b;
            ALU_AND:  alu_result_o = op_a & op_b;
            // upper immediate already placed by decode
            ALU_LUI:  alu_result_o = imm_i;
            default:  alu_result_o = '0;
        endcase
    end

endmodule

/* div_unit.sv */
module div_unit (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       div_start_i,
    input  logic                       div_signed_i,
    input  logic                       div_rem_i,
    input  logic [core_pkg::XLEN-1:0]  dividend_i,
    input  logic [core_pkg::XLEN-1:0]  divisor_i,
    output logic                       div_busy_o,
    output logic                       div_done_o,
    output logic [core_pkg::XLEN-1:0]  div_result_o
);
    import core_pkg::*;

    logic                 busy_q;
    logic [DIV_CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]      quo_q;
    logic [XLEN-1:0]      rem_q;
    logic [XLEN-1:0]      dsr_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic                 want_rem_q;
    logic                 zero_q;
    logic [XLEN-1:0]      abs_a;
    logic [XLEN-1:0]      abs_b;
    logic [XLEN:0]        diff;
    logic                 step_en;

    // magnitudes, -2^31 stays 0x8000_0000 and divides correctly as unsigned
    assign abs_a = (div_signed_i && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
    assign abs_b = (div_signed_i && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

    // trial subtract of the shifted partial remainder
    assign diff    = {rem_q, quo_q[XLEN-1]} - {1'b0, dsr_q};
    assign step_en = busy_q && (cnt_q != DIV_CNT_W'(DIV_STEPS));

    assign div_busy_o = busy_q;
    assign div_done_o = busy_q && (cnt_q == DIV_CNT_W'(DIV_STEPS));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (div_start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
        end else if (div_done_o) begin
            busy_q <= 1'b0;
        end else if (step_en) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (div_start_i) begin
            quo_q      <= abs_a;
            rem_q      <= '0;
            dsr_q      <= abs_b;
            neg_quo_q  <= div_signed_i && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
            neg_rem_q  <= div_signed_i && dividend_i[XLEN-1];
            want_rem_q <= div_rem_i;
            zero_q     <= (divisor_i == '0);
        end else if (step_en) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // remainder sign follows the dividend; x/0 gives all ones
    always_comb begin
        if (want_rem_q) begin
            div_result_o = neg_rem_q ? -rem_q : rem_q;
        end else if (zero_q) begin
            div_result_o = '1;
        end else begin
            div_result_o = neg_quo_q ? -quo_q : quo_q;
        end
    end

endmodule

/* retire_stage.sv */
module retire_stage (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             exec_valid_i,
    input  logic                             is_div_i,
    input  logic [core_pkg::REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [core_pkg::XLEN-1:0]        alu_result_i,
    input  logic                             div_done_i,
    input  logic [core_pkg::XLEN-1:0]        div_result_i,
    output logic                             rf_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rf_waddr_o,
    output logic [core_pkg::XLEN-1:0]        rf_wdata_o,
    output logic                             retire_valid_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  retire_rd_o,
    output logic [core_pkg::XLEN-1:0]        retire_data_o
);
    import core_pkg::*;

    logic                  alu_take;
    logic                  capture;
    logic                  valid_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [XLEN-1:0]       data_q;

    // divides retire only on done, the IR still holds their rd then
    assign alu_take = exec_valid_i && !is_div_i;
    assign capture  = alu_take || div_done_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= capture;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            rd_q   <= rd_addr_i;
            data_q <= div_done_i ? div_result_i : alu_result_i;
        end
    end

    // one register feeds write-back and trace
    assign rf_we_o        = valid_q;
    assign rf_waddr_o     = rd_q;
    assign rf_wdata_o     = data_q;
    assign retire_valid_o = valid_q;
    assign retire_rd_o    = rd_q;
    assign retire_data_o  = data_q;

endmodule

/* core_top.sv */
module core_top (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [core_pkg::XLEN-1:0]        rom_data_i,
    output logic                             rom_ce_o,
    output logic [core_pkg::XLEN-1:0]        rom_addr_o,
    output logic                             retire_valid_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  retire_rd_o,
    output logic [core_pkg::XLEN-1:0]        retire_data_o
);
    import core_pkg::*;

    // decode outputs
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  exec_valid;
    logic [ALU_OP_W-1:0]   alu_op;
    logic                  use_imm;
    logic [XLEN-1:0]       imm;
    logic                  is_div;
    logic                  div_start;
    logic                  div_signed;
    logic                  div_rem;

    // operands and results
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_result;
    logic                  div_busy;
    logic                  div_done;
    logic [XLEN-1:0]       div_result;

    // write-back port
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    frontend frontend_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rom_data_i   (rom_data_i),
        .div_busy_i   (div_busy),
        .div_done_i   (div_done),
        .rom_ce_o     (rom_ce_o),
        .rom_addr_o   (rom_addr_o),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rd_addr_o    (rd_addr),
        .exec_valid_o (exec_valid),
        .alu_op_o     (alu_op),
        .use_imm_o    (use_imm),
        .imm_o        (imm),
        .is_div_o     (is_div),
        .div_start_o  (div_start),
        .div_signed_o (div_signed),
        .div_rem_o    (div_rem)
    );

    regfile regfile_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    alu_unit alu_unit_i (
        .alu_op_i     (alu_op),
        .use_imm_i    (use_imm),
        .imm_i        (imm),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .alu_result_o (alu_result)
    );

    div_unit div_unit_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .div_start_i  (div_start),
        .div_signed_i (div_signed),
        .div_rem_i    (div_rem),
        .dividend_i   (rs1_data),
        .divisor_i    (rs2_data),
        .div_busy_o   (div_busy),
        .div_done_o   (div_done),
        .div_result_o (div_result)
    );

    retire_stage retire_stage_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .exec_valid_i   (exec_valid),
        .is_div_i       (is_div),
        .rd_addr_i      (rd_addr),
        .alu_result_i   (alu_result),
        .div_done_i     (div_done),
        .div_result_i   (div_result),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

/* core_tb.sv */
module core_tb;
    import core_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int DRIVE_DLY  = 1;
    localparam int ROM_AW     = 10;
    localparam int RAND_COUNT = 120;
    localparam int MAX_CYCLES = 20000;
    // fetch address holds from the cycle after div_start until done
    localparam int DIV_HOLD   = 33;
    localparam int KIND_REG   = 0;
    localparam int KIND_IMM   = 1;
    localparam int KIND_LUI   = 2;
    localparam int KIND_DIV   = 3;

    logic                  clk_i;
    logic                  rst_n_i;
    logic [XLEN-1:0]       rom_data_i;
    logic                  rom_ce_o;
    logic [XLEN-1:0]       rom_addr_o;
    logic                  retire_valid_o;
    logic [REG_ADDR_W-1:0] retire_rd_o;
    logic [XLEN-1:0]       retire_data_o;

    logic [XLEN-1:0]       rom [2**ROM_AW];
    logic [XLEN-1:0]       shadow [32];
    int                    prog_len;
    logic [31:0]           lfsr_state;
    logic [REG_ADDR_W-1:0] last_rd;
    int                    exp_kind [$];
    logic [REG_ADDR_W-1:0] exp_rd [$];
    logic [XLEN-1:0]       exp_data [$];

    int                    cycle = 0;
    logic [XLEN-1:0]       prev_addr;
    logic                  held;
    int                    run_len;
    int                    last_run;
    int                    kind;
    logic [REG_ADDR_W-1:0] want_rd;
    logic [XLEN-1:0]       want_data;

    core_top core_top_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .rom_data_i     (rom_data_i),
        .rom_ce_o       (rom_ce_o),
        .rom_addr_o     (rom_addr_o),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // combinational ROM, sampled just after the edge that moves the PC
    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        #DRIVE_DLY;
        rom_data_i <= rom[rom_addr_o[ROM_AW+1:2]];
    end

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic fail_msg(input string text);
        $display("error: %s", text);
        stop_run();
    endtask

    task automatic fail_value(input string test, input string what,
                              input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
        $display("mismatch %s %s expected %h actual %h", test, what, exp, act);
        stop_run();
    endtask

    function automatic string kind_name(input int k);
        case (k)
            KIND_REG: return "alu_reg";
            KIND_IMM: return "alu_imm";
            KIND_LUI: return "lui";
            default:  return "divide";
        endcase
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // integer ops by funct3, shift amount is the low 5 bits
    function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return XLEN'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
            3'd3:    return XLEN'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return (a >> sh) |
                            ((alt && a[31]) ? ~({XLEN{1'b1}} >> sh) : {XLEN{1'b0}});
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // div/divu/rem/remu with the zero divisor and overflow rules
    function automatic logic [XLEN-1:0] div_ref(input logic [2:0] f3,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [XLEN-1:0] q;
        logic [XLEN-1:0] r;
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (!f3[0] && a == 32'h8000_0000 && b == '1) begin
            q = a;
            r = '0;
        end else if (!f3[0]) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return f3[1] ? r : q;
    endfunction

    task automatic add_word(input logic [XLEN-1:0] w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic expect_retire(input int k, input logic [REG_ADDR_W-1:0] rd,
                                 input logic [XLEN-1:0] v);
        exp_kind.push_back(k);
        exp_rd.push_back(rd);
        exp_data.push_back(v);
        if (rd != '0) begin
            shadow[rd] = v;
        end
        last_rd = rd;
    endtask

    task automatic emit_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        inst_u w;
        w.r_view.funct7 = f7;
        w.r_view.rs2    = rs2;
        w.r_view.rs1    = rs1;
        w.r_view.funct3 = f3;
        w.r_view.rd     = rd;
        w.r_view.opcode = OPC_OP;
        add_word(w);
        if (f7 == FUNCT7_MULDIV) begin
            expect_retire(KIND_DIV, rd, div_ref(f3, shadow[rs1], shadow[rs2]));
        end else begin
            expect_retire(KIND_REG, rd, alu_ref(f3, f7 == FUNCT7_ALT, shadow[rs1], shadow[rs2]));
        end
    endtask

    // shifts put the arithmetic bit and shamt into imm12
    task automatic emit_i(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [11:0] imm);
        inst_u           w;
        logic [11:0]     imm12;
        logic [XLEN-1:0] b;
        imm12 = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]} : imm;
        b     = {{(XLEN-12){imm12[11]}}, imm12};
        w.i_view.imm12  = imm12;
        w.i_view.rs1    = rs1;
        w.i_view.funct3 = f3;
        w.i_view.rd     = rd;
        w.i_view.opcode = OPC_OP_IMM;
        add_word(w);
        expect_retire(KIND_IMM, rd, alu_ref(f3, alt && f3 == 3'd5, shadow[rs1], b));
    endtask

    task automatic emit_lui(input logic [4:0] rd, input logic [19:0] upper);
        add_word({upper, rd, OPC_LUI});
        expect_retire(KIND_LUI, rd, {upper, 12'h000});
    endtask

    // dropped opcodes and the multiply group, none of these retire
    task automatic emit_dropped();
        logic [2:0] pick;
        inst_u      w;
        pick = 3'(rand_bits(3));
        w    = inst_u'(rand_bits(25) << 7);
        case (pick)
            3'd0: w.r_view.opcode = 7'b0000011;
            3'd1: w.r_view.opcode = 7'b0100011;
            3'd2: w.r_view.opcode = 7'b1100011;
            3'd3: w.r_view.opcode = 7'b1101111;
            3'd4: w.r_view.opcode = 7'b1110011;
            3'd5: w.r_view.opcode = 7'b0010111;
            default: begin
                w.r_view.opcode    = OPC_OP;
                w.r_view.funct7    = FUNCT7_MULDIV;
                w.r_view.funct3[2] = 1'b0;
            end
        endcase
        add_word(w);
    endtask

    task automatic build_program();
        logic [2:0] sel;
        logic [2:0] f3;
        logic       alt;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        // the ADDI reads its LUI result straight from the bypass
        for (int r = 1; r < 32; r++) begin
            emit_lui(5'(r), 20'(rand_bits(20)));
            emit_i(3'd0, 1'b0, 5'(r), 5'(r), 12'(rand_bits(12)));
        end
        // most negative by minus one, then a reader right behind the divide
        emit_lui(5'd1, 20'h80000);
        emit_i(3'd0, 1'b0, 5'd2, 5'd0, 12'hfff);
        emit_r(FUNCT7_MULDIV, 3'd4, 5'd3, 5'd1, 5'd2);
        emit_r(FUNCT7_MULDIV, 3'd6, 5'd4, 5'd1, 5'd2);
        emit_r(7'd0, 3'd0, 5'd6, 5'd3, 5'd4);
        emit_r(FUNCT7_MULDIV, 3'd5, 5'd5, 5'd1, 5'd2);
        for (int k = 4; k < 8; k++) begin
            emit_r(FUNCT7_MULDIV, 3'(k), 5'(7 + k), 5'd6, 5'd0);
        end
        // remainder follows the dividend sign
        emit_i(3'd0, 1'b0, 5'd15, 5'd0, 12'hff9);
        emit_i(3'd0, 1'b0, 5'd16, 5'd0, 12'd2);
        emit_r(FUNCT7_MULDIV, 3'd6, 5'd17, 5'd15, 5'd16);
        emit_r(FUNCT7_MULDIV, 3'd4, 5'd18, 5'd15, 5'd16);
        for (int n = 0; n < RAND_COUNT; n++) begin
            sel = 3'(rand_bits(3));
            rd  = 5'(rand_bits(5));
            rs1 = rand_bits(1) ? last_rd : 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            f3  = 3'(rand_bits(3));
            alt = rand_bits(1) != 0;
            case (sel)
                3'd0, 3'd1: emit_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? FUNCT7_ALT : 7'd0,
                                   f3, rd, rs1, rs2);
                3'd2, 3'd3: emit_i(f3, alt, rd, rs1, 12'(rand_bits(12)));
                3'd4:       emit_lui(rd, 20'(rand_bits(20)));
                3'd5, 3'd6: emit_r(FUNCT7_MULDIV, {1'b1, f3[1:0]}, rd, rs1,
                                   (rs2[4:3] == 2'b00) ? 5'd0 : rs2);
                default:    emit_dropped();
            endcase
        end
        // x0 ignores the write, the next reader still sees zero
        emit_i(3'd0, 1'b0, 5'd0, 5'd1, 12'd5);
        emit_r(7'd0, 3'd0, 5'd19, 5'd0, 5'd0);
        emit_dropped();
    endtask

    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            if (cycle > 0) begin
                assert (!retire_valid_o) else fail_msg("retire pulse while in reset");
                assert (rom_addr_o == RESET_PC)
                    else fail_value("reset", "rom_addr_o", RESET_PC, rom_addr_o);
            end
            run_len  = 0;
            last_run = 0;
        end else begin
            held = (rom_addr_o == prev_addr);
            if (held) begin
                run_len++;
            end else begin
                last_run = run_len;
                run_len  = 0;
            end
            assert (rom_addr_o < XLEN'(4 * 2**ROM_AW)) else fail_msg("fetch ran past the ROM");
            if (retire_valid_o) begin
                assert (exp_rd.size() != 0) else fail_msg("retirement with nothing left to retire");
                kind      = exp_kind.pop_front();
                want_rd   = exp_rd.pop_front();
                want_data = exp_data.pop_front();
                assert (!held) else fail_msg("retirement while a divide held the fetch address");
                assert (retire_rd_o == want_rd)
                    else fail_value(kind_name(kind), "rd", XLEN'(want_rd), XLEN'(retire_rd_o));
                assert (retire_data_o == want_data)
                    else fail_value(kind_name(kind), "data", want_data, retire_data_o);
                if (kind == KIND_DIV) begin
                    assert (last_run == DIV_HOLD)
                        else fail_value("divide", "stall cycles", XLEN'(DIV_HOLD), XLEN'(last_run));
                end
            end
        end
        prev_addr = rom_addr_o;
    end

    initial begin
        clk_i      = 1'b0;
        rst_n_i    = 1'b0;
        rom_data_i = '0;
        lfsr_state = 32'h6d55;
        prog_len   = 0;
        last_rd    = '0;
        // unused words decode as fence and never retire
        for (int i = 0; i < 2**ROM_AW; i++) begin
            rom[i] = {25'(i), 7'b0001111};
        end
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        build_program();
        repeat (16) @(posedge clk_i);
        #DRIVE_DLY;
        rst_n_i = 1'b1;
        @(posedge clk_i);
        @(negedge clk_i);
        assert (rom_ce_o) else fail_msg("rom_ce_o did not rise in the first cycle after reset");
        assert (rom_addr_o == RESET_PC)
            else fail_value("reset", "first fetch address", RESET_PC, rom_addr_o);
        for (int t = 0; t < MAX_CYCLES && exp_rd.size() != 0; t++) begin
            @(posedge clk_i);
        end
        // trailing no-ops must stay silent
        for (int t = 0; t < 40 && exp_rd.size() == 0; t++) begin
            @(posedge clk_i);
        end
        if (exp_rd.size() != 0) begin
            $display("error: timeout with %0d retirements outstanding", exp_rd.size());
            stop_run();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* compile.f */
core_pkg.sv
frontend.sv
regfile.sv
alu_unit.sv
div_unit.sv
retire_stage.sv
core_top.sv
core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - core_pkg.sv
  - frontend.sv
  - regfile.sv
  - alu_unit.sv
  - div_unit.sv
  - retire_stage.sv
  - core_top.sv
  - target: test
    files:
      - core_tb.sv
